// File: sim.f
hdl/conv_pkg.sv
hdl/true_dpbram.sv
hdl/conv_apb_regs.sv
hdl/conv_data_mover.sv
hdl/pe_row.sv
hdl/conv_top.sv
bench/conv_assert.sv
bench/tb_conv_top.sv

// File: bench/tb_conv_top.sv
`timescale 1ns/1ps

module tb_conv_top;
    import conv_pkg::*;

    localparam int PE_SIZE    = 16;
    localparam int MEM_DEPTH  = 896;
    localparam int ADDR_WIDTH = 10;
    localparam int LINE_W     = PE_SIZE * LANE_W;
    localparam int WORDS      = LINE_W / APB_DATA_W;
    localparam int CLK_PERIOD = 100;
    // 1 + 20 + 1 + 1 + 1 runs, each allowed a full RAM load and some slack
    localparam int RUNS       = 24;
    localparam longint WATCHDOG_CYCLES = RUNS * (MEM_DEPTH * 4 + 200);

    logic        clk;
    logic        arst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [LINE_W-1:0] wgt_mem [MEM_DEPTH];
    logic [LINE_W-1:0] act_mem [MEM_DEPTH];
    int          errors = 0;
    int          checks = 0;
    int          check_len;
    event        check_req;
    event        check_ack;

    conv_top #(
        .PE_SIZE(PE_SIZE),
        .MEM_DEPTH(MEM_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_conv_top (
        .clk(clk),
        .arst_n_i(arst_n),
        .apb_req_i(apb_req),
        .apb_rsp_o(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic apb_addr_t reg_addr(input logic [REG_OFS_W-1:0] ofs);
        return {REGION_REGS, ofs};
    endfunction

    function automatic apb_addr_t mem_addr(input logic [1:0] region, input int idx,
                                           input int word);
        return {region, idx[ADDR_WIDTH-1:0], word[1:0], 2'b00};
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // signed dot product of one lane over lines 0 to len-1
    function automatic acc_t expected_acc(input int lane, input int len);
        lane_t w;
        lane_t a;
        int    sum;
        sum = 0;
        for (int i = 0; i < len; i++) begin
            w = wgt_mem[i][lane*LANE_W +: LANE_W];
            a = act_mem[i][lane*LANE_W +: LANE_W];
            sum += int'(w) * int'(a);
        end
        return acc_t'(sum);
    endfunction

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d",
                     $time, name, $signed(got), $signed(exp));
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check_value("pready", apb_data_t'(apb_rsp.pready), 32'd1);
        @(posedge clk);
        apb_req <= '0;
    endtask

    // prdata is taken in the middle of the access phase
    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        check_value("pready", apb_data_t'(apb_rsp.pready), 32'd1);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic load_pair(input int idx, input logic [LINE_W-1:0] wgt,
                             input logic [LINE_W-1:0] act);
        wgt_mem[idx] = wgt;
        act_mem[idx] = act;
        for (int w = 0; w < WORDS; w++) begin
            apb_write(mem_addr(REGION_MEM0, idx, w), wgt[w*APB_DATA_W +: APB_DATA_W]);
        end
        for (int w = 0; w < WORDS; w++) begin
            apb_write(mem_addr(REGION_MEM1, idx, w), act[w*APB_DATA_W +: APB_DATA_W]);
        end
    endtask

    task automatic wait_done();
        apb_data_t status;
        status = '0;
        while (!status[1]) begin
            apb_read(reg_addr(REG_STATUS), status);
        end
    endtask

    task automatic compare_accs(input int len);
        check_len = len;
        -> check_req;
        @(check_ack);
    endtask

    task automatic run_and_check(input int len);
        apb_write(reg_addr(REG_LEN), apb_data_t'(len));
        apb_write(reg_addr(REG_CTRL), 32'd1);
        wait_done();
        compare_accs(len);
    endtask

    // reads back every lane and compares it with the reference
    initial begin : compare
        apb_data_t got;
        forever begin
            @(check_req);
            for (int k = 0; k < PE_SIZE; k++) begin
                apb_read(reg_addr(REG_ACC_BASE + REG_OFS_W'(4 * k)), got);
                check_value($sformatf("acc[%0d]", k), got, expected_acc(k, check_len));
            end
            -> check_ack;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        apb_data_t status;
        int        len;
        void'($urandom(32'h5943_9521));
        apb_req = '0;
        arst_n  = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // idle status and cleared accumulators after reset
        apb_read(reg_addr(REG_STATUS), status);
        check_value("status", status, '0);
        compare_accs(0);

        for (int i = 0; i < 8; i++) begin
            load_pair(i, random_line(), random_line());
        end
        run_and_check(8);

        // every run must start from cleared accumulators
        repeat (20) begin
            len = 1 + int'($urandom % 64);
            for (int i = 0; i < len; i++) begin
                load_pair(i, random_line(), random_line());
            end
            run_and_check(len);
        end

        run_and_check(0);

        // the second start lands while the first run is still busy
        for (int i = 0; i < 40; i++) begin
            load_pair(i, random_line(), random_line());
        end
        apb_write(reg_addr(REG_LEN), 32'd40);
        apb_write(reg_addr(REG_CTRL), 32'd1);
        apb_write(reg_addr(REG_LEN), 32'd10);
        apb_write(reg_addr(REG_CTRL), 32'd1);
        wait_done();
        compare_accs(40);

        // most negative operands over the whole depth
        for (int i = 0; i < MEM_DEPTH; i++) begin
            load_pair(i, {PE_SIZE{8'h80}}, {PE_SIZE{8'h80}});
        end
        run_and_check(MEM_DEPTH);

        errors += i_conv_top.i_mover.i_conv_assert.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/conv_assert.sv
`timescale 1ns/1ps

module conv_assert (
    input logic clk,
    input logic arst_n_i,
    input logic start_i,
    input logic ce_i,
    input logic valid_i,
    input logic busy_i,
    input logic finish_i
);

    // high from a finish pulse until the next start reaches the mover
    logic stopped_q;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stopped_q <= 1'b0;
        end else if (start_i) begin
            stopped_q <= 1'b0;
        end else if (finish_i) begin
            stopped_q <= 1'b1;
        end
    end

    a_valid_after_ce: assert property (@(posedge clk) disable iff (!arst_n_i)
        ce_i |=> valid_i)
        else begin
            fail_count++;
            $error("valid did not follow a RAM read by one cycle");
        end

    a_valid_needs_ce: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i |-> $past(ce_i))
        else begin
            fail_count++;
            $error("valid without a RAM read in the cycle before");
        end

    a_ce_in_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        ce_i |-> busy_i)
        else begin
            fail_count++;
            $error("RAM read enable while the mover is not busy");
        end

    a_no_ce_after_finish: assert property (@(posedge clk) disable iff (!arst_n_i)
        ce_i |-> !stopped_q)
        else begin
            fail_count++;
            $error("RAM read enable after finish without a new start");
        end

endmodule

bind conv_data_mover conv_assert i_conv_assert (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .start_i(start_i),
    .ce_i(mem0_ce0_o),
    .valid_i(valid_o),
    .busy_i(busy_o),
    .finish_i(finish_o)
);

// File: hdl/conv_top.sv
`timescale 1ns/1ps

module conv_top #(
    parameter int PE_SIZE    = 16,
    parameter int MEM_DEPTH  = 896,
    parameter int ADDR_WIDTH = 10
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  conv_pkg::apb_req_t apb_req_i,
    output conv_pkg::apb_rsp_t apb_rsp_o
);
    import conv_pkg::*;

    localparam int LINE_W = PE_SIZE * LANE_W;

    logic                  start;
    logic [ADDR_WIDTH:0]   len;
    logic                  mem0_wr;
    logic                  mem1_wr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [LINE_W-1:0]     wr_line;
    logic [ADDR_WIDTH-1:0] mem0_addr0;
    logic [ADDR_WIDTH-1:0] mem1_addr0;
    logic                  mem0_ce0;
    logic                  mem1_ce0;
    logic [LINE_W-1:0]     mem0_q0;
    logic [LINE_W-1:0]     mem1_q0;
    logic                  clear;
    logic                  valid;
    logic                  busy;
    logic                  finish;
    acc_t [PE_SIZE-1:0]    acc;

    conv_apb_regs #(
        .PE_SIZE(PE_SIZE),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_regs (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .apb_req_i(apb_req_i),
        .apb_rsp_o(apb_rsp_o),
        .busy_i(busy),
        .finish_i(finish),
        .acc_i(acc),
        .start_o(start),
        .len_o(len),
        .mem0_wr_o(mem0_wr),
        .mem1_wr_o(mem1_wr),
        .wr_addr_o(wr_addr),
        .wr_line_o(wr_line)
    );

    // weights, port 0 only reads and port 1 only writes
    true_dpbram #(
        .DWIDTH(LINE_W),
        .AWIDTH(ADDR_WIDTH),
        .MEM_SIZE(MEM_DEPTH)
    ) mem0 (
        .clk(clk),
        .addr0_i(mem0_addr0),
        .ce0_i(mem0_ce0),
        .we0_i(1'b0),
        .d0_i('0),
        .q0_o(mem0_q0),
        .addr1_i(wr_addr),
        .ce1_i(mem0_wr),
        .we1_i(mem0_wr),
        .d1_i(wr_line),
        .q1_o()
    );

    // activations, same port usage as the weight RAM
    true_dpbram #(
        .DWIDTH(LINE_W),
        .AWIDTH(ADDR_WIDTH),
        .MEM_SIZE(MEM_DEPTH)
    ) mem1 (
        .clk(clk),
        .addr0_i(mem1_addr0),
        .ce0_i(mem1_ce0),
        .we0_i(1'b0),
        .d0_i('0),
        .q0_o(mem1_q0),
        .addr1_i(wr_addr),
        .ce1_i(mem1_wr),
        .we1_i(mem1_wr),
        .d1_i(wr_line),
        .q1_o()
    );

    conv_data_mover #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_mover (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .start_i(start),
        .len_i(len),
        .mem0_addr0_o(mem0_addr0),
        .mem0_ce0_o(mem0_ce0),
        .mem1_addr0_o(mem1_addr0),
        .mem1_ce0_o(mem1_ce0),
        .clear_o(clear),
        .valid_o(valid),
        .busy_o(busy),
        .finish_o(finish)
    );

    pe_row #(
        .PE_SIZE(PE_SIZE)
    ) i_pe_row (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .clear_i(clear),
        .valid_i(valid),
        .wgt_i(mem0_q0),
        .act_i(mem1_q0),
        .acc_o(acc)
    );

endmodule

// File: hdl/pe_row.sv
`timescale 1ns/1ps

module pe_row #(
    parameter int PE_SIZE = 16
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                clear_i,
    input  logic                                valid_i,
    input  logic [PE_SIZE*conv_pkg::LANE_W-1:0] wgt_i,
    input  logic [PE_SIZE*conv_pkg::LANE_W-1:0] act_i,
    output conv_pkg::acc_t [PE_SIZE-1:0]        acc_o
);
    import conv_pkg::*;

    for (genvar i = 0; i < PE_SIZE; i++) begin : g_lane
        lane_t w_lane;
        lane_t a_lane;
        acc_t  prod;
        acc_t  acc_q;

        // lane i sits at byte i of the line
        assign w_lane = lane_t'(wgt_i[i*LANE_W +: LANE_W]);
        assign a_lane = lane_t'(act_i[i*LANE_W +: LANE_W]);

        // both casts sign-extend, so the product is a full signed multiply
        assign prod = acc_t'(w_lane) * acc_t'(a_lane);

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                acc_q <= '0;
            end else if (clear_i) begin
                acc_q <= '0;
            end else if (valid_i) begin
                acc_q <= acc_q + prod;
            end
        end

        assign acc_o[i] = acc_q;
    end

endmodule

// File: hdl/conv_data_mover.sv
`timescale 1ns/1ps

module conv_data_mover #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  start_i,
    input  logic [ADDR_WIDTH:0]   len_i,
    output logic [ADDR_WIDTH-1:0] mem0_addr0_o,
    output logic                  mem0_ce0_o,
    output logic [ADDR_WIDTH-1:0] mem1_addr0_o,
    output logic                  mem1_ce0_o,
    output logic                  clear_o,
    output logic                  valid_o,
    output logic                  busy_o,
    output logic                  finish_o
);
    import conv_pkg::*;

    mover_state_e          state_q;
    mover_state_e          state_d;
    logic [ADDR_WIDTH-1:0] cnt_q;
    logic [ADDR_WIDTH:0]   len_q;
    logic                  accept;
    logic                  ce;
    logic                  last_line;

    // a start is taken in idle and also in the finish cycle of the last run
    assign accept    = start_i && ((state_q == IDLE) || (state_q == FINISH));
    assign ce        = (state_q == READ);
    assign last_line = ({1'b0, cnt_q} == (len_q - 1'b1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, FINISH: begin
                if (start_i) begin
                    state_d = (len_i == '0) ? DRAIN : READ;
                end else begin
                    state_d = IDLE;
                end
            end
            READ: begin
                if (last_line) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: state_d = FINISH;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            len_q   <= '0;
            clear_o <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            clear_o <= accept;
            // RAM data shows up one cycle after the enable
            valid_o <= ce;
            if (accept) begin
                cnt_q <= '0;
                len_q <= len_i;
            end else if (ce) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // both RAMs walk the same line index
    assign mem0_addr0_o = cnt_q;
    assign mem1_addr0_o = cnt_q;
    assign mem0_ce0_o   = ce;
    assign mem1_ce0_o   = ce;

    assign busy_o   = (state_q == READ) || (state_q == DRAIN);
    assign finish_o = (state_q == FINISH);

endmodule

// File: hdl/conv_apb_regs.sv
`timescale 1ns/1ps

module conv_apb_regs #(
    parameter int PE_SIZE    = 16,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  conv_pkg::apb_req_t                  apb_req_i,
    output conv_pkg::apb_rsp_t                  apb_rsp_o,
    input  logic                                busy_i,
    input  logic                                finish_i,
    input  conv_pkg::acc_t [PE_SIZE-1:0]        acc_i,
    output logic                                start_o,
    output logic [ADDR_WIDTH:0]                 len_o,
    output logic                                mem0_wr_o,
    output logic                                mem1_wr_o,
    output logic [ADDR_WIDTH-1:0]               wr_addr_o,
    output logic [PE_SIZE*conv_pkg::LANE_W-1:0] wr_line_o
);
    import conv_pkg::*;

    localparam int LINE_W   = PE_SIZE * LANE_W;
    localparam int WORDS    = LINE_W / APB_DATA_W;
    localparam int WORD_W   = $clog2(WORDS);
    localparam int LINE_LSB = 2 + WORD_W;
    localparam int IDX_W    = $clog2(PE_SIZE);

    logic                  wr_en;
    logic                  rd_en;
    logic [1:0]            region;
    logic [REG_OFS_W-1:0]  offset;
    logic [REG_OFS_W-1:0]  acc_ofs;
    logic                  acc_hit;
    logic [IDX_W-1:0]      acc_idx;
    logic                  mem_sel;
    logic [WORD_W-1:0]     word_sel;
    logic                  last_word;
    logic [ADDR_WIDTH-1:0] line_sel;
    logic [LINE_W-1:0]     line_q;
    logic                  done_q;
    apb_data_t             rdata;

    // all decoding happens in the access phase
    assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign rd_en = apb_req_i.psel && apb_req_i.penable && !apb_req_i.pwrite;

    assign region = apb_req_i.paddr[APB_ADDR_W-1 -: 2];
    assign offset = apb_req_i.paddr[REG_OFS_W-1:0];

    assign acc_ofs = offset - REG_ACC_BASE;
    assign acc_hit = (offset >= REG_ACC_BASE) && ((acc_ofs >> 2) < PE_SIZE);
    assign acc_idx = acc_ofs[2 +: IDX_W];

    // memory regions, bits 3:2 pick the word and the bits above pick the line
    assign mem_sel   = (region == REGION_MEM0) || (region == REGION_MEM1);
    assign word_sel  = apb_req_i.paddr[2 +: WORD_W];
    assign line_sel  = apb_req_i.paddr[LINE_LSB +: ADDR_WIDTH];
    assign last_word = (word_sel == WORD_W'(WORDS - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_o   <= 1'b0;
            len_o     <= '0;
            done_q    <= 1'b0;
            mem0_wr_o <= 1'b0;
            mem1_wr_o <= 1'b0;
        end else begin
            start_o <= wr_en && (region == REGION_REGS) && (offset == REG_CTRL)
                       && apb_req_i.pwdata[0] && !busy_i;
            // the full line goes to the RAM one cycle after its last word
            mem0_wr_o <= wr_en && last_word && (region == REGION_MEM0);
            mem1_wr_o <= wr_en && last_word && (region == REGION_MEM1);
            if (wr_en && (region == REGION_REGS) && (offset == REG_LEN)) begin
                len_o <= apb_req_i.pwdata[ADDR_WIDTH:0];
            end
            // a new run clears done even if the previous one finishes now
            if (start_o) begin
                done_q <= 1'b0;
            end else if (finish_i) begin
                done_q <= 1'b1;
            end
        end
    end

    // line staging buffer, the last word lands here together with the commit
    always_ff @(posedge clk) begin
        if (wr_en && mem_sel) begin
            line_q[word_sel*APB_DATA_W +: APB_DATA_W] <= apb_req_i.pwdata;
            if (last_word) begin
                wr_addr_o <= line_sel;
            end
        end
    end

    assign wr_line_o = line_q;

    always_comb begin
        rdata = '0;
        if (rd_en && (region == REGION_REGS)) begin
            if (offset == REG_LEN) begin
                rdata = apb_data_t'(len_o);
            end else if (offset == REG_STATUS) begin
                rdata = apb_data_t'({done_q, busy_i});
            end else if (acc_hit) begin
                rdata = apb_data_t'(acc_i[acc_idx]);
            end
        end
        apb_rsp_o.prdata = rdata;
        apb_rsp_o.pready = 1'b1;
    end

endmodule

// File: hdl/true_dpbram.sv
`timescale 1ns/1ps

module true_dpbram #(
    parameter int DWIDTH   = 128,
    parameter int AWIDTH   = 10,
    parameter int MEM_SIZE = 896
) (
    input  logic              clk,

    input  logic [AWIDTH-1:0] addr0_i,
    input  logic              ce0_i,
    input  logic              we0_i,
    input  logic [DWIDTH-1:0] d0_i,
    output logic [DWIDTH-1:0] q0_o,

    input  logic [AWIDTH-1:0] addr1_i,
    input  logic              ce1_i,
    input  logic              we1_i,
    input  logic [DWIDTH-1:0] d1_i,
    output logic [DWIDTH-1:0] q1_o
);

    logic [DWIDTH-1:0] ram [MEM_SIZE];

    // port 0, a write leaves the output register untouched
    always @(posedge clk) begin
        if (ce0_i) begin
            if (we0_i) begin
                ram[addr0_i] <= d0_i;
            end else begin
                q0_o <= ram[addr0_i];
            end
        end
    end

    // port 1 behaves the same way
    always @(posedge clk) begin
        if (ce1_i) begin
            if (we1_i) begin
                ram[addr1_i] <= d1_i;
            end else begin
                q1_o <= ram[addr1_i];
            end
        end
    end

endmodule

// File: hdl/conv_pkg.sv
package conv_pkg;

    // operand and accumulator widths of one PE lane
    localparam int LANE_W = 8;
    localparam int ACC_W  = 32;

    localparam int APB_ADDR_W = 16;
    localparam int APB_DATA_W = 32;

    // paddr bits below the region field address registers or RAM words
    localparam int REG_OFS_W = 14;

    typedef logic signed [LANE_W-1:0] lane_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [APB_ADDR_W-1:0]    apb_addr_t;
    typedef logic [APB_DATA_W-1:0]    apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
    } apb_rsp_t;

    // region select on paddr[15:14]
    localparam logic [1:0] REGION_REGS = 2'd0;
    localparam logic [1:0] REGION_MEM0 = 2'd1;
    localparam logic [1:0] REGION_MEM1 = 2'd2;

    localparam logic [REG_OFS_W-1:0] REG_CTRL     = 14'h000;
    localparam logic [REG_OFS_W-1:0] REG_LEN      = 14'h004;
    localparam logic [REG_OFS_W-1:0] REG_STATUS   = 14'h008;
    localparam logic [REG_OFS_W-1:0] REG_ACC_BASE = 14'h100;

    typedef enum logic [1:0] {IDLE, READ, DRAIN, FINISH} mover_state_e;

endpackage
